// File: sim.f
src/game_pkg.sv
src/key_debounce.sv
src/game_control.sv
src/arrow_sequencer.sv
src/miss_judge.sv
src/game_status.sv
src/game_top.sv
verification/game_tb.sv

// File: run.sh
#!/bin/sh
# build and run the game testbench, exit status follows the simulation
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module game_tb -f sim.f -o game_sim &&
./obj_dir/game_sim || exit 1

// File: verification/game_tb.sv
module game_tb;

	import game_pkg::*;

	localparam int CYCLE_LIMIT = 30000; // two games of up to 16 slow steps plus the speed sweep
	localparam int HOLD        = 24;    // cycles a button level is held

	typedef struct packed
	{
		logic [15:0] status;
		logic [31:0] arrows;
		lamps_t      l1;
		lamps_t      l2;
	} expect_t;

	logic        clk;
	logic        arst_n;
	logic        speed_up;
	logic        two_player;
	logic        btn_speed;
	logic        btn_pause;
	arrow_keys_t keys_p1 = '0;
	arrow_keys_t keys_p2 = '0;
	buttons_t    buttons;
	logic [15:0] status_digits;
	logic [31:0] arrow_digits;
	lamps_t      lamps_p1;
	lamps_t      lamps_p2;

	// model state
	logic [1:0]  m_speed;
	logic        m_run;
	logic [3:0]  m_index;
	logic [2:0]  m_miss1;
	logic [2:0]  m_miss2;
	logic        cmp_en;
	int          key_mode;        // 0 correct keys, 1 random keys
	int          cycles;
	int          steps_seen;
	int          last_step_cycle;
	integer      seed;
	expect_t     exp_now;

	assign buttons = {btn_speed, btn_pause, keys_p1, keys_p2};

	game_top dut0
	(
		.clk           (clk),
		.arst_n        (arst_n),
		.buttons       (buttons),
		.speed_up      (speed_up),
		.two_player    (two_player),
		.status_digits (status_digits),
		.arrow_digits  (arrow_digits),
		.lamps_p1      (lamps_p1),
		.lamps_p2      (lamps_p2)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic logic [15:0] glyph_of(input arrow_e a);
		case (a)
			ARROW_UP:    return 16'hf01f;
			ARROW_DOWN:  return 16'hf23f;
			ARROW_LEFT:  return 16'h4566;
			default:     return 16'h6657;
		endcase
	endfunction

	function automatic logic [3:0] key_mask(input arrow_e a);
		case (a)
			ARROW_UP:    return 4'b1000;
			ARROW_DOWN:  return 4'b0100;
			ARROW_LEFT:  return 4'b0010;
			default:     return 4'b0001;
		endcase
	endfunction

	function automatic logic is_over(input logic two, input logic [2:0] m1, input logic [2:0] m2);
		return (m1 == 3'd4) || (two && (m2 == 3'd4));
	endfunction

	function automatic expect_t expected(input logic [1:0] spd, input logic rn, input logic two,
		input logic [2:0] m1, input logic [2:0] m2, input cue_t c);
		expect_t e;
		if (is_over(two, m1, m2))
		begin
			e.status = 16'h5bc6;
			e.arrows = 32'he8b9_ffff;
		end
		else if (!rn)
		begin
			e.status = 16'h5bc6;
			e.arrows = 32'hcbdd_efff;
		end
		else
		begin
			e.status = 16'h5671 + {14'd0, spd};
			e.arrows = {glyph_of(c.p1), two ? glyph_of(c.p2) : 16'hffff};
		end
		e.l1 = 4'b1111 << m1; // p1 bar empties from the right
		e.l2 = two ? (4'b1111 >> m2) : 4'b0000;
		return e;
	endfunction

	// correct key plus random extras, or random keys without the right one
	function automatic arrow_keys_t pick_keys(input arrow_e a, input int mode);
		logic [31:0] r;
		r = $random(seed);
		if (mode == 1 && r[4])
			return arrow_keys_t'(r[3:0] & ~key_mask(a));
		return arrow_keys_t'(r[3:0] | key_mask(a));
	endfunction

	task automatic mismatch(input string name, input logic [31:0] exp_v, input logic [31:0] act_v);
		$display("FAILED time %0t %s expected %h actual %h", $time, name, exp_v, act_v);
		$display(">>> FAIL");
		$fatal(1, "output mismatch");
	endtask

	//////////////////////////////////////////////////////////////////////
	// comparing process, also follows the step pulse

	always @(negedge clk)
	begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout: the game did not finish within %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$fatal(1, "timeout");
		end
		if (!arst_n)
		begin
			m_index = 4'd0;
			m_miss1 = 3'd0;
			m_miss2 = 3'd0;
			keys_p1 = pick_keys(PATTERN[0].p1, 0);
			keys_p2 = pick_keys(PATTERN[0].p2, 0);
		end
		else
		begin
			exp_now = expected(m_speed, m_run, two_player, m_miss1, m_miss2, PATTERN[m_index]);
			if (cmp_en)
			begin
				assert (status_digits == exp_now.status)
				else mismatch("status_digits", {16'd0, exp_now.status}, {16'd0, status_digits});
				assert (arrow_digits == exp_now.arrows)
				else mismatch("arrow_digits", exp_now.arrows, arrow_digits);
				assert (lamps_p1 == exp_now.l1)
				else mismatch("lamps_p1", {28'd0, exp_now.l1}, {28'd0, lamps_p1});
				assert (lamps_p2 == exp_now.l2)
				else mismatch("lamps_p2", {28'd0, exp_now.l2}, {28'd0, lamps_p2});
			end
			if (dut0.u_control.step)
			begin
				last_step_cycle = cycles;
				steps_seen      = steps_seen + 1;
				if (m_run && !is_over(two_player, m_miss1, m_miss2))
				begin
					if ((keys_p1 & key_mask(PATTERN[m_index].p1)) == 4'd0 && m_miss1 != 3'd4)
						m_miss1 = m_miss1 + 3'd1;
					if (two_player && (keys_p2 & key_mask(PATTERN[m_index].p2)) == 4'd0
						&& m_miss2 != 3'd4)
						m_miss2 = m_miss2 + 3'd1;
					m_index = m_index + 4'd1; // wraps after 16 steps
				end
				keys_p1 = pick_keys(PATTERN[m_index].p1, key_mode);
				keys_p2 = pick_keys(PATTERN[m_index].p2, key_mode);
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// stimulus

	task automatic apply_reset(input logic two);
		arst_n     = 1'b0;
		two_player = two;
		key_mode   = 0;
		m_speed    = 2'd0;
		m_run      = 1'b0;
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
	endtask

	task automatic wait_steps(input int n);
		int target;
		target = steps_seen + n;
		while (steps_seen < target)
			@(negedge clk);
	endtask

	// checks pause while the debounced level ripples through
	task automatic press_speed(input logic up);
		@(negedge clk);
		speed_up  = up;
		btn_speed = 1'b1;
		cmp_en    = 1'b0;
		m_speed   = up ? m_speed + 2'd1 : m_speed - 2'd1;
		repeat (HOLD) @(negedge clk);
		btn_speed = 1'b0;
		cmp_en    = 1'b1;
		repeat (HOLD) @(negedge clk);
	endtask

	task automatic press_pause();
		if (m_run)
			wait_steps(1); // keep the toggle clear of the next step
		@(negedge clk);
		btn_pause = 1'b1;
		cmp_en    = 1'b0;
		m_run     = ~m_run;
		repeat (HOLD) @(negedge clk);
		btn_pause = 1'b0;
		cmp_en    = 1'b1;
		repeat (HOLD) @(negedge clk);
	endtask

	task automatic check_period();
		int t0;
		int want;
		int got;
		wait_steps(2); // new speed is latched at a step wrap
		t0 = last_step_cycle;
		wait_steps(1);
		got  = last_step_cycle - t0;
		want = (4 - int'(m_speed)) * STEP_DIV;
		assert (got >= want - 2 && got <= want + 2)
		else mismatch("step_period", want, got);
	endtask

	task automatic play_to_over();
		key_mode = 1;
		while (!is_over(two_player, m_miss1, m_miss2))
			@(negedge clk);
		repeat (300) @(negedge clk); // over display and frozen cue
	endtask

	initial
	begin
		seed            = 32'hc010_e8d8;
		arst_n          = 1'b0;
		speed_up        = 1'b1;
		two_player      = 1'b0;
		btn_speed       = 1'b0;
		btn_pause       = 1'b0;
		cmp_en          = 1'b1;
		key_mode        = 0;
		cycles          = 0;
		steps_seen      = 0;
		last_step_cycle = 0;
		m_speed         = 2'd0;
		m_run           = 1'b0;

		// one player, start with correct keys
		apply_reset(1'b0);
		repeat (40) @(negedge clk);
		press_pause();
		check_period();

		// sweep the speed both ways with wrap
		press_speed(1'b1);
		check_period();
		press_speed(1'b1);
		check_period();
		press_speed(1'b1);
		check_period();
		press_speed(1'b1);
		check_period();
		press_speed(1'b0);
		check_period();
		press_speed(1'b0);
		check_period();

		// stop, cue must hold, then resume
		press_pause();
		repeat (200) @(negedge clk);
		press_pause();
		wait_steps(2);

		play_to_over();

		// two players from a fresh reset
		apply_reset(1'b1);
		repeat (40) @(negedge clk);
		press_pause();
		wait_steps(2);
		play_to_over();

		$display(">>> PASS");
		$finish;
	end

endmodule

// File: src/game_top.sv
module game_top
(
	input  logic               clk,
	input  logic               arst_n,
	input  game_pkg::buttons_t buttons,
	input  logic               speed_up,
	input  logic               two_player,
	output logic [15:0]        status_digits,
	output logic [31:0]        arrow_digits,
	output game_pkg::lamps_t   lamps_p1,
	output game_pkg::lamps_t   lamps_p2
);

	import game_pkg::*;

	buttons_t   clean;
	logic [1:0] speed;
	logic       run;
	logic       step;
	logic       play;
	logic       play_p2;
	cue_t       cue;
	miss_t      misses_p1;
	miss_t      misses_p2;

	assign play_p2 = play & two_player; // lane 2 judged only with two players

	//////////////////////////////////////////////////////////////////////
	// input side

	key_debounce u_debounce
	(
		.clk    (clk),
		.arst_n (arst_n),
		.raw    (buttons),
		.clean  (clean)
	);

	game_control u_control
	(
		.clk       (clk),
		.arst_n    (arst_n),
		.speed_btn (clean.speed_btn),
		.pause_btn (clean.pause_btn),
		.speed_up  (speed_up),
		.speed     (speed),
		.run       (run),
		.step      (step)
	);

	arrow_sequencer u_sequencer
	(
		.clk    (clk),
		.arst_n (arst_n),
		.step   (step),
		.play   (play),
		.cue    (cue)
	);

	//////////////////////////////////////////////////////////////////////
	// judging and status

	miss_judge u_judge_p1
	(
		.clk    (clk),
		.arst_n (arst_n),
		.step   (step),
		.enable (play),
		.arrow  (cue.p1),
		.keys   (clean.keys_p1),
		.misses (misses_p1)
	);

	miss_judge u_judge_p2
	(
		.clk    (clk),
		.arst_n (arst_n),
		.step   (step),
		.enable (play_p2),
		.arrow  (cue.p2),
		.keys   (clean.keys_p2),
		.misses (misses_p2)
	);

	game_status u_status
	(
		.run           (run),
		.speed         (speed),
		.two_player    (two_player),
		.cue           (cue),
		.misses_p1     (misses_p1),
		.misses_p2     (misses_p2),
		.play          (play),
		.status_digits (status_digits),
		.arrow_digits  (arrow_digits),
		.lamps_p1      (lamps_p1),
		.lamps_p2      (lamps_p2)
	);

endmodule

// File: src/game_status.sv
module game_status
(
	input  logic              run,
	input  logic [1:0]        speed,
	input  logic              two_player,
	input  game_pkg::cue_t    cue,
	input  game_pkg::miss_t   misses_p1,
	input  game_pkg::miss_t   misses_p2,
	output logic              play,
	output logic [15:0]       status_digits,
	output logic [31:0]       arrow_digits,
	output game_pkg::lamps_t  lamps_p1,
	output game_pkg::lamps_t  lamps_p2
);

	import game_pkg::*;

	logic        p1_out;
	logic        p2_out;
	logic        over;
	logic [15:0] glyph_p1;
	logic [15:0] glyph_p2;

	//////////////////////////////////////////////////////////////////////
	// game state

	assign p1_out = (misses_p1 == miss_t'(MAX_MISS));
	assign p2_out = (misses_p2 == miss_t'(MAX_MISS));
	assign over   = p1_out | (two_player & p2_out); // p2 ignored when playing alone
	assign play   = run & ~over;

	//////////////////////////////////////////////////////////////////////
	// life bars

	always_comb
	begin
		lamps_p1 = LAMPS_P1[misses_p1];
		if (two_player)
			lamps_p2 = LAMPS_P2[misses_p2];
		else
			lamps_p2 = '0; // lane 2 dark in one-player mode
	end

	//////////////////////////////////////////////////////////////////////
	// display words

	assign glyph_p1 = GLYPH[cue.p1];
	assign glyph_p2 = two_player ? GLYPH[cue.p2] : GLYPH_BLANK;

	always_comb
	begin
		if (over)
		begin
			status_digits = CODE_STOP;
			arrow_digits  = CODE_OVER;
		end
		else if (!run)
		begin
			status_digits = CODE_STOP;
			arrow_digits  = CODE_HELLO;
		end
		else
		begin
			status_digits = CODE_SPEED_BASE + {14'd0, speed}; // last digit 1..4
			arrow_digits  = {glyph_p1, glyph_p2};
		end
	end

endmodule

// File: src/miss_judge.sv
module miss_judge
(
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  step,
	input  logic                  enable,
	input  game_pkg::arrow_e      arrow,
	input  game_pkg::arrow_keys_t keys,
	output game_pkg::miss_t       misses
);

	import game_pkg::*;

	logic key_held;
	logic full;

	// only the key of the shown arrow counts
	always_comb
	begin
		case (arrow)
			ARROW_UP:    key_held = keys.up;
			ARROW_DOWN:  key_held = keys.down;
			ARROW_LEFT:  key_held = keys.left;
			ARROW_RIGHT: key_held = keys.right;
			default:     key_held = 1'b0;
		endcase
	end

	assign full = (misses == miss_t'(MAX_MISS));

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			misses <= '0;
		else if (step && enable && !key_held && !full)
			misses <= misses + 1'b1;
	end

endmodule

// File: src/arrow_sequencer.sv
module arrow_sequencer
(
	input  logic           clk,
	input  logic           arst_n,
	input  logic           step,
	input  logic           play,
	output game_pkg::cue_t cue
);

	import game_pkg::*;

	logic [SEQ_W-1:0] index;
	logic [SEQ_W-1:0] next_index;
	logic             advance;

	assign advance    = step & play;
	assign next_index = advance ? index + 1'b1 : index; // wraps after the last entry

	// cue is looked up from the next index so it changes with the index
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			index <= '0;
			cue   <= PATTERN[0];
		end
		else
		begin
			index <= next_index;
			cue   <= PATTERN[next_index];
		end
	end

endmodule

// File: src/game_control.sv
module game_control
(
	input  logic       clk,
	input  logic       arst_n,
	input  logic       speed_btn,
	input  logic       pause_btn,
	input  logic       speed_up,
	output logic [1:0] speed,
	output logic       run,
	output logic       step
);

	import game_pkg::*;

	logic                  speed_btn_q;
	logic                  pause_btn_q;
	logic                  speed_rise;
	logic                  pause_rise;
	logic [STEP_CNT_W-1:0] tick_cnt;
	logic                  base_tick;
	logic [1:0]            step_cnt;  // base ticks into the current step
	logic [1:0]            step_last; // limit latched at the step wrap
	logic                  step_wrap;

	assign speed_rise = speed_btn & ~speed_btn_q;
	assign pause_rise = pause_btn & ~pause_btn_q;
	assign base_tick  = run && (tick_cnt == STEP_CNT_W'(STEP_DIV - 1));
	assign step_wrap  = base_tick && (step_cnt >= step_last);

	//////////////////////////////////////////////////////////////////////
	// buttons

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			speed_btn_q <= 1'b0;
			pause_btn_q <= 1'b0;
			speed       <= 2'd0;
			run         <= 1'b0;
		end
		else
		begin
			speed_btn_q <= speed_btn;
			pause_btn_q <= pause_btn;
			if (speed_rise)
				speed <= speed_up ? speed + 2'd1 : speed - 2'd1; // wraps both ways
			if (pause_rise)
				run <= ~run;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// step timing

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			tick_cnt  <= '0;
			step_cnt  <= 2'd0;
			step_last <= 2'd3;
			step      <= 1'b0;
		end
		else
		begin
			step <= step_wrap;
			if (run)
				tick_cnt <= tick_cnt + 1'b1; // wraps every STEP_DIV cycles
			if (step_wrap)
				step_cnt <= 2'd0;
			else if (base_tick)
				step_cnt <= step_cnt + 2'd1;
			if (!run || step_wrap)
				step_last <= 2'd3 - speed;
		end
	end

endmodule

// File: src/key_debounce.sv
module key_debounce
(
	input  logic              clk,
	input  logic              arst_n,
	input  game_pkg::buttons_t raw,
	output game_pkg::buttons_t clean
);

	import game_pkg::*;

	logic [DEB_CNT_W-1:0] div_cnt;
	logic                 sample_en;
	logic [NUM_BTN-1:0]   raw_bits;
	logic [NUM_BTN-1:0]   clean_bits;
	logic [DEB_LEN-1:0]   shreg [NUM_BTN];

	assign raw_bits  = raw;
	assign sample_en = (div_cnt == DEB_CNT_W'(DEB_DIV - 1));
	assign clean     = buttons_t'(clean_bits);

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			div_cnt <= '0;
		else if (sample_en)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	// one history per button, newest sample in bit 0
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			for (int i = 0; i < NUM_BTN; i++)
				shreg[i] <= '0;
			clean_bits <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_BTN; i++)
			begin
				if (sample_en)
					shreg[i] <= {shreg[i][DEB_LEN-2:0], raw_bits[i]};
				if (&shreg[i])
					clean_bits[i] <= 1'b1; // stable high
				else if (~|shreg[i])
					clean_bits[i] <= 1'b0; // stable low
			end
		end
	end

endmodule

// File: src/game_pkg.sv
package game_pkg;

	//////////////////////////////////////////////////////////////////////
	// types

	typedef enum logic [1:0]
	{
		ARROW_UP,
		ARROW_DOWN,
		ARROW_LEFT,
		ARROW_RIGHT
	} arrow_e;

	typedef struct packed
	{
		logic up;
		logic down;
		logic left;
		logic right;
	} arrow_keys_t;

	typedef struct packed
	{
		logic        speed_btn;
		logic        pause_btn;
		arrow_keys_t keys_p1;
		arrow_keys_t keys_p2;
	} buttons_t;

	typedef struct packed
	{
		arrow_e p1; // upper display half
		arrow_e p2; // lower display half
	} cue_t;

	typedef logic [2:0] miss_t;
	typedef logic [3:0] lamps_t;

	//////////////////////////////////////////////////////////////////////
	// timing

	localparam int DEB_DIV    = 2;  // about 25000 on the board
	localparam int DEB_LEN    = 8;
	localparam int STEP_DIV   = 32; // base tick, a step is (4 - speed) ticks
	localparam int MAX_MISS   = 4;
	localparam int SEQ_LEN    = 16;
	localparam int NUM_BTN    = $bits(buttons_t);
	localparam int DEB_CNT_W  = $clog2(DEB_DIV);
	localparam int STEP_CNT_W = $clog2(STEP_DIV);
	localparam int SEQ_W      = $clog2(SEQ_LEN);

	// player 1 arrow, player 2 arrow per step
	localparam cue_t PATTERN [SEQ_LEN] = '{
		'{ARROW_UP,    ARROW_LEFT},  '{ARROW_LEFT,  ARROW_UP},
		'{ARROW_RIGHT, ARROW_DOWN},  '{ARROW_RIGHT, ARROW_RIGHT},
		'{ARROW_LEFT,  ARROW_DOWN},  '{ARROW_DOWN,  ARROW_RIGHT},
		'{ARROW_UP,    ARROW_UP},    '{ARROW_LEFT,  ARROW_UP},
		'{ARROW_RIGHT, ARROW_LEFT},  '{ARROW_DOWN,  ARROW_RIGHT},
		'{ARROW_RIGHT, ARROW_DOWN},  '{ARROW_UP,    ARROW_LEFT},
		'{ARROW_DOWN,  ARROW_UP},    '{ARROW_LEFT,  ARROW_LEFT},
		'{ARROW_UP,    ARROW_RIGHT}, '{ARROW_DOWN,  ARROW_UP}
	};

	//////////////////////////////////////////////////////////////////////
	// display symbol codes, one nibble per digit

	localparam logic [15:0] GLYPH [4] = '{16'hf01f, 16'hf23f, 16'h4566, 16'h6657};
	localparam logic [15:0] GLYPH_BLANK     = 16'hffff;
	localparam logic [31:0] CODE_HELLO      = 32'hcbdd_efff;
	localparam logic [31:0] CODE_OVER       = 32'he8b9_ffff;
	localparam logic [15:0] CODE_STOP       = 16'h5bc6;
	localparam logic [15:0] CODE_SPEED_BASE = 16'h5671; // "spd1" at speed 0

	// life bars, p2 empties from the other side
	localparam lamps_t LAMPS_P1 [MAX_MISS+1] = '{4'b1111, 4'b1110, 4'b1100, 4'b1000, 4'b0000};
	localparam lamps_t LAMPS_P2 [MAX_MISS+1] = '{4'b1111, 4'b0111, 4'b0011, 4'b0001, 4'b0000};

endpackage
